// ==== compile.f ====
+incdir+include
hw/hist_pkg.sv
hw/sync_dp_ram.sv
hw/hist_update.sv
hw/hist_host_ctrl.sv
hw/hist_top.sv
dv/hist_checker.sv
dv/hist_tb.sv

// ==== dv/hist_checker.sv ====
////////////////////////////////////////
// bound assertions on RAM ports, host
// response and busy after reset
////////////////////////////////////////

`timescale 1ns/1ns

module hist_checker
  import hist_pkg::*;
(
  input logic     Clk_CI,
  input logic     Rst_RBI,
  input logic     acq_en,
  input logic     rsp_valid,
  input logic     busy,
  input ram_req_t ram_req_a,
  input ram_req_t ram_req_b
);

  // write strobes per port
  logic wr_a;
  logic wr_b;

  // number of failed assertions
  int unsigned fail_cnt = 0;

  assign wr_a = ram_req_a.csel & ram_req_a.wr_en;
  assign wr_b = ram_req_b.csel & ram_req_b.wr_en;

  // never two writes to one address in a cycle
  a_no_dual_write: assert property (
    @(posedge Clk_CI) disable iff (!Rst_RBI)
    !(wr_a && wr_b && (ram_req_a.addr == ram_req_b.addr))
  ) else begin
    fail_cnt++;
    $error("both RAM ports write address %0d", ram_req_a.addr);
  end

  // host responses only with acquisition off
  a_no_rsp_in_acq: assert property (
    @(posedge Clk_CI) disable iff (!Rst_RBI)
    rsp_valid |-> !acq_en
  ) else begin
    fail_cnt++;
    $error("host response while acq_en is high");
  end

  // unit comes out of reset not busy
  a_idle_after_reset: assert property (
    @(posedge Clk_CI)
    $rose(Rst_RBI) |=> !busy
  ) else begin
    fail_cnt++;
    $error("busy high one cycle after reset release");
  end

endmodule

bind hist_top hist_checker u_hist_checker (
  .Clk_CI    (Clk_CI),
  .Rst_RBI   (Rst_RBI),
  .acq_en    (acq_en),
  .rsp_valid (rsp_valid),
  .busy      (busy),
  .ram_req_a (ram_req_a),
  .ram_req_b (ram_req_b)
);

// ==== dv/hist_tb.sv ====
////////////////////////////////////////
// histogram testbench: stimulus, count
// model, response compare, timeout
////////////////////////////////////////

`timescale 1ns/1ns

`include "hist_cfg.svh"

module hist_tb
  import hist_pkg::*;
();

  localparam int DEPTH   = `HIST_DEPTH;
  localparam int CNT_MAX = (1 << `HIST_CNT_W) - 1;
  // rough length of the whole sequence in cycles
  localparam int TEST_CYCLES = 1100;
  localparam int MAX_CYCLES  = 5 * TEST_CYCLES;

  logic                   Clk_CI;
  logic                   Rst_RBI;
  logic                   acq_en;
  logic                   sample_valid;
  logic [`HIST_BIN_W-1:0] sample_bin;
  logic                   cmd_valid;
  hist_cmd_t              cmd;
  logic                   rsp_valid;
  hist_rsp_t              rsp;
  logic                   busy;

  // raw sample counts per bin, unsaturated
  int unsigned exp_cnt [DEPTH];
  // bins of reads still waiting for a response
  int unsigned pend_bins [$];
  int unsigned mon_bin;
  // acq_en as seen at the last edge
  logic        acq_seen;
  int          cycle_cnt = 0;
  integer      seed;

  hist_top u_hist_top (
    .Clk_CI       (Clk_CI),
    .Rst_RBI      (Rst_RBI),
    .acq_en       (acq_en),
    .sample_valid (sample_valid),
    .sample_bin   (sample_bin),
    .cmd_valid    (cmd_valid),
    .cmd          (cmd),
    .rsp_valid    (rsp_valid),
    .rsp          (rsp),
    .busy         (busy)
  );

  initial begin
    Clk_CI = 1'b0;
    forever begin
      #5 Clk_CI = ~Clk_CI;
    end
  end

  ////////////////////////////////////////
  // reporting
  ////////////////////////////////////////

  task automatic stop_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    stop_run();
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string msg);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s, got %0d, expected %0d", $time, msg, got, exp);
      stop_run();
    end
  endtask

  // any failed bound assertion ends the run
  always @(u_hist_top.u_hist_checker.fail_cnt) begin
    if (u_hist_top.u_hist_checker.fail_cnt != 0) begin
      report_failure("a bound assertion on the DUT failed");
    end
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // counters stop at their maximum
  function automatic int unsigned ref_count(input int unsigned b);
    if (exp_cnt[b] > CNT_MAX) begin
      return CNT_MAX;
    end
    return exp_cnt[b];
  endfunction

  // sample counts only after acq_en was high a full cycle
  always @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      acq_seen <= 1'b0;
    end else begin
      acq_seen <= acq_en;
    end
  end

  // responses are registered, so stable at the falling edge
  always @(negedge Clk_CI) begin
    if (Rst_RBI && rsp_valid) begin
      if (pend_bins.size() == 0) begin
        report_failure("a host response appeared with no read pending");
      end else begin
        mon_bin = pend_bins.pop_front();
        check_value(rsp.bin, mon_bin, "response bin");
        check_value(rsp.count, ref_count(mon_bin), $sformatf("count of bin %0d", mon_bin));
      end
    end
  end

  always @(posedge Clk_CI) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      report_failure($sformatf("timeout, the run went past %0d cycles", MAX_CYCLES));
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic drive_sample(input int unsigned b);
    sample_valid = 1'b1;
    sample_bin   = `HIST_BIN_W'(b);
    if (acq_en && acq_seen) begin
      exp_cnt[b] = exp_cnt[b] + 1;
    end
  endtask

  task automatic send_sample(input int unsigned b);
    @(negedge Clk_CI);
    drive_sample(b);
  endtask

  task automatic end_samples();
    @(negedge Clk_CI);
    sample_valid = 1'b0;
  endtask

  task automatic drive_cmd(input hist_op_e op, input int unsigned b);
    @(negedge Clk_CI);
    cmd_valid = 1'b1;
    cmd.op    = op;
    cmd.bin   = `HIST_BIN_W'(b);
  endtask

  task automatic end_cmds();
    @(negedge Clk_CI);
    cmd_valid = 1'b0;
  endtask

  task automatic read_all_bins();
    for (int b = 0; b < DEPTH; b++) begin
      drive_cmd(HIST_OP_READ, b);
      pend_bins.push_back(b);
    end
    end_cmds();
    // last response seen at the previous falling edge
    @(negedge Clk_CI);
    check_value(pend_bins.size(), 0, "responses missing after reads");
  endtask

  task automatic clear_all();
    int n;
    drive_cmd(HIST_OP_CLEAR, 0);
    end_cmds();
    n = 0;
    while (busy) begin
      n = n + 1;
      @(negedge Clk_CI);
    end
    check_value(n, DEPTH, "busy cycles of clear sweep");
    foreach (exp_cnt[i]) exp_cnt[i] = 0;
  endtask

  // drop acq_en, then wait for the drain
  task automatic stop_acq();
    @(negedge Clk_CI);
    acq_en       = 1'b0;
    sample_valid = 1'b0;
    @(negedge Clk_CI);
    while (busy) begin
      @(negedge Clk_CI);
    end
  endtask

  task automatic start_acq();
    @(negedge Clk_CI);
    acq_en = 1'b1;
  endtask

  ////////////////////////////////////////
  // sequence
  ////////////////////////////////////////

  initial begin
    seed         = 32'hc506_7cc6;
    Rst_RBI      = 1'b0;
    // acquisition on through reset
    acq_en       = 1'b1;
    sample_valid = 1'b0;
    sample_bin   = '0;
    cmd_valid    = 1'b0;
    cmd          = '0;
    foreach (exp_cnt[i]) exp_cnt[i] = 0;
    repeat (2) @(negedge Clk_CI);
    Rst_RBI = 1'b1;

    // clear, all bins zero
    stop_acq();
    clear_all();
    read_all_bins();

    // random bins, one sample per cycle
    start_acq();
    repeat (200) send_sample($unsigned($random(seed)) % DEPTH);
    end_samples();
    stop_acq();
    read_all_bins();

    // bursts and alternating bins hit forwarding
    clear_all();
    start_acq();
    repeat (20) send_sample(3);
    for (int i = 0; i < 30; i++) send_sample((i % 2 == 0) ? 10 : 11);
    for (int i = 0; i < 20; i++) send_sample(((i / 2) % 2 == 0) ? 20 : 21);
    end_samples();
    stop_acq();
    read_all_bins();

    // saturation of bin 7, neighbours mixed in
    start_acq();
    for (int i = 0; i < 300; i++) begin
      if (i % 20 == 9) begin
        send_sample(6);
      end else if (i % 20 == 19) begin
        send_sample(8);
      end else begin
        send_sample(7);
      end
    end
    end_samples();
    stop_acq();
    read_all_bins();

    // samples with acq_en low
    for (int i = 0; i < 20; i++) send_sample(i * 3 % DEPTH);
    end_samples();
    // sample and host read in the guard cycle, still in idle
    @(negedge Clk_CI);
    acq_en    = 1'b1;
    drive_sample(5);
    cmd_valid = 1'b1;
    cmd.op    = HIST_OP_READ;
    cmd.bin   = `HIST_BIN_W'(5);
    end_samples();
    cmd_valid = 1'b0;
    // host commands with acq_en high
    drive_cmd(HIST_OP_READ, 3);
    drive_cmd(HIST_OP_CLEAR, 0);
    drive_cmd(HIST_OP_READ, 7);
    end_cmds();
    stop_acq();
    read_all_bins();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== hw/hist_host_ctrl.sv ====
////////////////////////////////////////
// RAM port ownership, host read and
// clear sweep FSM
////////////////////////////////////////

`timescale 1ns/1ns

`include "hist_cfg.svh"

module hist_host_ctrl
  import hist_pkg::*;
(
  input  logic                   Clk_CI,
  input  logic                   Rst_RBI,
  input  logic                   acq_en,
  input  logic                   cmd_valid,
  input  hist_cmd_t              cmd,
  input  ram_req_t               upd_req_a,
  input  ram_req_t               upd_req_b,
  input  logic                   upd_idle,
  input  logic [`HIST_CNT_W-1:0] rdata_a,
  output ram_req_t               ram_req_a,
  output ram_req_t               ram_req_b,
  output logic                   rsp_valid,
  output hist_rsp_t              rsp,
  output logic                   busy
);

  // last bin of the clear sweep
  localparam logic [`HIST_BIN_W-1:0] LAST_BIN = `HIST_BIN_W'(`HIST_DEPTH - 1);

  ////////////////////////////////////////
  // signals
  ////////////////////////////////////////

  hist_state_e            state_q;
  hist_state_e            state_d;

  // clear sweep address
  logic [`HIST_BIN_W-1:0] clr_addr_q;

  // accepted host commands
  logic                   cmd_ok;
  logic                   rd_go;
  logic                   clr_go;

  // response
  logic                   rsp_valid_q;
  logic [`HIST_BIN_W-1:0] rsp_bin_q;

  // host side port requests
  ram_req_t               host_req_a;
  ram_req_t               host_req_b;

  ////////////////////////////////////////
  // command decode
  ////////////////////////////////////////

  // commands only count in idle with acquisition off
  assign cmd_ok = cmd_valid & (state_q == ST_IDLE) & ~acq_en;
  assign rd_go  = cmd_ok & (cmd.op == HIST_OP_READ);
  assign clr_go = cmd_ok & (cmd.op == HIST_OP_CLEAR);

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_ACQ: begin
        if (!acq_en) begin
          state_d = ST_DRAIN;
        end
      end
      ST_DRAIN: begin
        // back to acquisition directly if acq_en came back meanwhile
        if (upd_idle) begin
          state_d = acq_en ? ST_ACQ : ST_IDLE;
        end
      end
      ST_IDLE: begin
        if (acq_en) begin
          state_d = ST_ACQ;
        end else if (clr_go) begin
          state_d = ST_CLEAR;
        end
      end
      ST_CLEAR: begin
        if (clr_addr_q == LAST_BIN) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_ACQ;
    endcase
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      state_q     <= ST_ACQ;
      clr_addr_q  <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      rsp_valid_q <= rd_go;
      // sweep one bin per cycle, start from bin 0
      if (clr_go) begin
        clr_addr_q <= '0;
      end else if (state_q == ST_CLEAR) begin
        clr_addr_q <= clr_addr_q + 1'b1;
      end
    end
  end

  // bin of the pending read
  always_ff @(posedge Clk_CI) begin
    if (rd_go) begin
      rsp_bin_q <= cmd.bin;
    end
  end

  ////////////////////////////////////////
  // RAM port selection
  ////////////////////////////////////////

  always_comb begin
    // port A reads for the host
    host_req_a.csel  = rd_go;
    host_req_a.wr_en = 1'b0;
    host_req_a.addr  = cmd.bin;
    host_req_a.wdata = '0;
    // port B writes zeros during the sweep
    host_req_b.csel  = (state_q == ST_CLEAR);
    host_req_b.wr_en = (state_q == ST_CLEAR);
    host_req_b.addr  = clr_addr_q;
    host_req_b.wdata = '0;
  end

  // update pipeline owns both ports only while acquiring
  assign ram_req_a = (state_q == ST_ACQ) ? upd_req_a : host_req_a;
  assign ram_req_b = (state_q == ST_ACQ) ? upd_req_b : host_req_b;

  ////////////////////////////////////////
  // outputs
  ////////////////////////////////////////

  assign rsp_valid = rsp_valid_q;
  assign rsp.bin   = rsp_bin_q;
  // read data arrives one cycle after the request
  assign rsp.count = rdata_a;

  assign busy = (state_q == ST_DRAIN) | (state_q == ST_CLEAR);

endmodule

// ==== hw/hist_pkg.sv ====
////////////////////////////////////////
// histogram types: host opcodes, host
// FSM states, command/response structs
////////////////////////////////////////

`include "hist_cfg.svh"

package hist_pkg;

  // host opcodes
  typedef enum logic [0:0] {
    HIST_OP_READ  = 1'b0,
    HIST_OP_CLEAR = 1'b1
  } hist_op_e;

  // host controller states
  typedef enum logic [1:0] {
    ST_ACQ   = 2'd0,
    ST_DRAIN = 2'd1,
    ST_IDLE  = 2'd2,
    ST_CLEAR = 2'd3
  } hist_state_e;

  // host command, 7 bits
  typedef struct packed {
    hist_op_e                op;
    logic [`HIST_BIN_W-1:0]  bin;
  } hist_cmd_t;

  // host response, 14 bits
  typedef struct packed {
    logic [`HIST_BIN_W-1:0]  bin;
    logic [`HIST_CNT_W-1:0]  count;
  } hist_rsp_t;

  // one RAM port request, 16 bits
  typedef struct packed {
    logic                    csel;
    logic                    wr_en;
    logic [`HIST_BIN_W-1:0]  addr;
    logic [`HIST_CNT_W-1:0]  wdata;
  } ram_req_t;

endpackage

// ==== hw/hist_top.sv ====
////////////////////////////////////////
// histogram unit top level
////////////////////////////////////////

`timescale 1ns/1ns

`include "hist_cfg.svh"

module hist_top
  import hist_pkg::*;
(
  input  logic                   Clk_CI,
  input  logic                   Rst_RBI,
  input  logic                   acq_en,
  input  logic                   sample_valid,
  input  logic [`HIST_BIN_W-1:0] sample_bin,
  input  logic                   cmd_valid,
  input  hist_cmd_t              cmd,
  output logic                   rsp_valid,
  output hist_rsp_t              rsp,
  output logic                   busy
);

  // update pipeline requests
  ram_req_t               upd_req_a;
  ram_req_t               upd_req_b;
  logic                   upd_idle;

  // arbitrated RAM requests
  ram_req_t               ram_req_a;
  ram_req_t               ram_req_b;
  logic [`HIST_CNT_W-1:0] ram_rdata_a;

  hist_update u_update (
    .Clk_CI       (Clk_CI),
    .Rst_RBI      (Rst_RBI),
    .acq_en       (acq_en),
    .sample_valid (sample_valid),
    .sample_bin   (sample_bin),
    .rdata_a      (ram_rdata_a),
    .upd_req_a    (upd_req_a),
    .upd_req_b    (upd_req_b),
    .upd_idle     (upd_idle)
  );

  hist_host_ctrl u_host (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .acq_en    (acq_en),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .upd_req_a (upd_req_a),
    .upd_req_b (upd_req_b),
    .upd_idle  (upd_idle),
    .rdata_a   (ram_rdata_a),
    .ram_req_a (ram_req_a),
    .ram_req_b (ram_req_b),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .busy      (busy)
  );

  // port B read data not needed, port B only writes
  sync_dp_ram #(
    .ADDR_WIDTH (`HIST_BIN_W),
    .DATA_DEPTH (`HIST_DEPTH),
    .DATA_WIDTH (`HIST_CNT_W)
  ) u_ram (
    .Clk_CI  (Clk_CI),
    .csel_a  (ram_req_a.csel),
    .wr_en_a (ram_req_a.wr_en),
    .addr_a  (ram_req_a.addr),
    .wdata_a (ram_req_a.wdata),
    .rdata_a (ram_rdata_a),
    .csel_b  (ram_req_b.csel),
    .wr_en_b (ram_req_b.wr_en),
    .addr_b  (ram_req_b.addr),
    .wdata_b (ram_req_b.wdata),
    .rdata_b ()
  );

endmodule

// ==== hw/hist_update.sv ====
////////////////////////////////////////
// histogram increment pipeline, read on
// port A, write on port B, forwarding
////////////////////////////////////////

`timescale 1ns/1ns

`include "hist_cfg.svh"

module hist_update
  import hist_pkg::*;
(
  input  logic                   Clk_CI,
  input  logic                   Rst_RBI,
  input  logic                   acq_en,
  input  logic                   sample_valid,
  input  logic [`HIST_BIN_W-1:0] sample_bin,
  input  logic [`HIST_CNT_W-1:0] rdata_a,
  output ram_req_t               upd_req_a,
  output ram_req_t               upd_req_b,
  output logic                   upd_idle
);

  // saturation value of a bin counter
  localparam logic [`HIST_CNT_W-1:0] CNT_MAX = '1;

  ////////////////////////////////////////
  // signals
  ////////////////////////////////////////

  // acq_en delayed by one cycle, acceptance guard
  logic                   acq_q;
  logic                   accept;

  // stage 1, waiting for read data
  logic                   s1_valid_q;
  logic [`HIST_BIN_W-1:0] s1_bin_q;

  // last write issued on port B
  logic                   wr_valid_q;
  logic [`HIST_BIN_W-1:0] wr_bin_q;
  logic [`HIST_CNT_W-1:0] wr_cnt_q;

  logic                   fwd;
  logic [`HIST_CNT_W-1:0] old_cnt;
  logic [`HIST_CNT_W-1:0] new_cnt;

  ////////////////////////////////////////
  // stage 0, accept and read
  ////////////////////////////////////////

  // sample only counts once acq_en has been high for a full cycle
  assign accept = sample_valid & acq_en & acq_q;

  always_comb begin
    upd_req_a.csel  = accept;
    upd_req_a.wr_en = 1'b0;
    upd_req_a.addr  = sample_bin;
    upd_req_a.wdata = '0;
  end

  ////////////////////////////////////////
  // stage 1, increment and write
  ////////////////////////////////////////

  // RAM data is stale if the previous cycle wrote this bin
  assign fwd     = wr_valid_q & (wr_bin_q == s1_bin_q);
  assign old_cnt = fwd ? wr_cnt_q : rdata_a;

  // plus one, held at the maximum
  assign new_cnt = (old_cnt == CNT_MAX) ? CNT_MAX : old_cnt + 1'b1;

  always_comb begin
    upd_req_b.csel  = s1_valid_q;
    upd_req_b.wr_en = s1_valid_q;
    upd_req_b.addr  = s1_bin_q;
    upd_req_b.wdata = new_cnt;
  end

  // nothing in either stage
  assign upd_idle = ~accept & ~s1_valid_q;

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  // control
  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      acq_q      <= 1'b0;
      s1_valid_q <= 1'b0;
      wr_valid_q <= 1'b0;
    end else begin
      acq_q      <= acq_en;
      s1_valid_q <= accept;
      wr_valid_q <= s1_valid_q;
    end
  end

  // payload, qualified by the valid flags above
  always_ff @(posedge Clk_CI) begin
    s1_bin_q <= sample_bin;
    wr_bin_q <= s1_bin_q;
    wr_cnt_q <= new_cnt;
  end

endmodule

// ==== hw/sync_dp_ram.sv ====
////////////////////////////////////////
// inferable synchronous dual-port RAM
////////////////////////////////////////

`timescale 1ns/1ns

module sync_dp_ram #(
  parameter int ADDR_WIDTH = 10,
  // normally 2**ADDR_WIDTH, may be less
  parameter int DATA_DEPTH = 1024,
  parameter int DATA_WIDTH = 32
) (
  input  logic                  Clk_CI,
  // port A
  input  logic                  csel_a,
  input  logic                  wr_en_a,
  input  logic [ADDR_WIDTH-1:0] addr_a,
  input  logic [DATA_WIDTH-1:0] wdata_a,
  output logic [DATA_WIDTH-1:0] rdata_a,
  // port B
  input  logic                  csel_b,
  input  logic                  wr_en_b,
  input  logic [ADDR_WIDTH-1:0] addr_b,
  input  logic [DATA_WIDTH-1:0] wdata_b,
  output logic [DATA_WIDTH-1:0] rdata_b
);

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  logic [DATA_WIDTH-1:0] mem [DATA_DEPTH];

  // registered read data per port
  logic [DATA_WIDTH-1:0] rdata_a_q;
  logic [DATA_WIDTH-1:0] rdata_b_q;

  ////////////////////////////////////////
  // port A
  ////////////////////////////////////////

  // write or read, never both in one cycle
  always @(posedge Clk_CI) begin
    if (csel_a) begin
      if (wr_en_a) begin
        mem[addr_a] <= wdata_a;
      end else begin
        rdata_a_q <= mem[addr_a];
      end
    end
  end

  ////////////////////////////////////////
  // port B
  ////////////////////////////////////////

  always @(posedge Clk_CI) begin
    if (csel_b) begin
      if (wr_en_b) begin
        mem[addr_b] <= wdata_b;
      end else begin
        rdata_b_q <= mem[addr_b];
      end
    end
  end

  // read data holds until the next read on that port
  assign rdata_a = rdata_a_q;
  assign rdata_b = rdata_b_q;

endmodule

// ==== include/hist_cfg.svh ====
////////////////////////////////////////
// histogram unit sizes: bin index,
// bin count and counter width
////////////////////////////////////////

`ifndef HIST_CFG_SVH
`define HIST_CFG_SVH

// width of a bin index
`define HIST_BIN_W 6

// number of bins, two to the power of the index width
`define HIST_DEPTH 64

// counter width, small enough to reach saturation in simulation
`define HIST_CNT_W 8

`endif
